//--- compile.f
src/core_pkg.sv
src/mem_pkg.sv
src/fetch_unit.sv
src/exec_unit.sv
src/mem_arbiter.sv
src/apb_mem_port.sv
src/tiny_core_top.sv
testbench/inst_trace_checker.sv
testbench/tb_tiny_core.sv

//--- testbench/tb_tiny_core.sv
// testbench for the tiny core: APB loading, ISA reference model and directed program tests
`timescale 1ns/1ns
`default_nettype none

module tb_tiny_core;
  import core_pkg::*;
  import mem_pkg::*;

  localparam int CLK_HALF     = 2;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_TESTS    = 6;
  // longest program the model will step
  localparam int MAX_STEPS    = 64;
  // load, run and readback per model step
  localparam int STEP_CYCLES  = 60;
  localparam int WATCHDOG_NS  = NUM_TESTS * MAX_STEPS * STEP_CYCLES * 2 * CLK_HALF;
  localparam int WAIT_LIMIT   = 200;
  localparam int HALT_WINDOW  = 16;
  // data area at byte 0x200
  localparam int DATA_BASE    = 128;

  logic     clk;
  logic     arst_n;
  logic     run;
  logic     psel;
  logic     penable;
  logic     pwrite;
  addr_t    paddr;
  word_t    pwdata;
  word_t    prdata;
  logic     pready;
  logic     trace_val;
  addr_t    trace_pc;
  logic     trace_wen;
  reg_idx_t trace_waddr;
  word_t    trace_wdata;
  logic     halted;

  int          errors;
  int          exp_commits;
  int          prog_len;
  logic [15:0] lfsr;

  // reference model state, memory mirrors the DUT across tests
  word_t    model_mem [MEM_WORDS];
  word_t    model_rf [32];
  addr_t    exp_pc_q [$];
  logic     exp_wen_q [$];
  reg_idx_t exp_waddr_q [$];
  word_t    exp_wdata_q [$];

  tiny_core_top tiny_core_top_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .run         (run),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_wen   (trace_wen),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .halted      (halted)
  );

  inst_trace_checker trace_checker_inst (
    .clk         (clk),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_wen   (trace_wen),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata)
  );

  always #CLK_HALF clk = ~clk;

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------

  // inputs change 1 ns after the rising edge
  task automatic drive_slot();
    @(posedge clk);
    #1;
  endtask

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = (v << 1) | word_t'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic word_t assemble(input opcode_e op, input int rd, input int rs1,
                                     input int rs2, input int imm);
    word_t w;
    w                 = '0;
    w[OPC_HI:OPC_LO]  = op;
    w[RD_HI:RD_LO]    = rd[4:0];
    w[RS1_HI:RS1_LO]  = rs1[4:0];
    w[RS2_HI:RS2_LO]  = rs2[4:0];
    w[IMM_HI:IMM_LO]  = imm[12:0];
    return w;
  endfunction

  task automatic restart_core();
    drive_slot();
    run    = 1'b0;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    if (trace_val !== 1'b0) begin
      $display("FAIL trace_val after reset: expected 0, got %h", trace_val);
      errors++;
    end
    if (halted !== 1'b0) begin
      $display("FAIL halted after reset: expected 0, got %h", halted);
      errors++;
    end
    if (pready !== 1'b0) begin
      $display("FAIL pready after reset: expected 0, got %h", pready);
      errors++;
    end
  endtask

  // setup phase, access phase, then wait for pready
  task automatic apb_access(input logic write, input addr_t addr, input word_t wdata,
                            output word_t rdata);
    int cycles;
    drive_slot();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    drive_slot();
    penable = 1'b1;
    cycles  = 0;
    @(negedge clk);
    while (pready !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (pready !== 1'b1) begin
      $display("APB access to %h ended without pready", addr);
      errors++;
    end
    rdata = prdata;
    drive_slot();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input addr_t addr, input word_t data);
    word_t unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input addr_t addr, output word_t data);
    apb_access(1'b0, addr, '0, data);
  endtask

  // write a word to the DUT and to the model
  task automatic poke_word(input int idx, input word_t data);
    model_mem[idx] = data;
    apb_write(addr_t'(idx * 4), data);
  endtask

  task automatic check_word(input int idx);
    word_t data;
    apb_read(addr_t'(idx * 4), data);
    if (data !== model_mem[idx]) begin
      $display("FAIL prdata at word %h: expected %h, got %h", idx, model_mem[idx], data);
      errors++;
    end
  endtask

  task automatic start_program();
    restart_core();
    prog_len = 0;
  endtask

  task automatic emit(input word_t w);
    poke_word(prog_len, w);
    prog_len++;
  endtask

  // ----------------------------------------
  // ISA reference model
  // ----------------------------------------

  task automatic add_expect(input addr_t pc, input logic wen, input reg_idx_t waddr,
                            input word_t wdata);
    exp_pc_q.push_back(pc);
    exp_wen_q.push_back(wen);
    exp_waddr_q.push_back(waddr);
    exp_wdata_q.push_back(wdata);
  endtask

  // r0 stays zero, a write to it reports wen low
  task automatic write_back(input addr_t pc, input reg_idx_t rd, input word_t res);
    add_expect(pc, rd != '0, rd, res);
    if (rd != '0) begin
      model_rf[rd] = res;
    end
  endtask

  task automatic model_run();
    addr_t    pc;
    addr_t    ea;
    word_t    w;
    word_t    a;
    word_t    b;
    word_t    imm;
    reg_idx_t rd;
    logic     done;
    pc   = RESET_PC;
    done = 1'b0;
    exp_pc_q.delete();
    exp_wen_q.delete();
    exp_waddr_q.delete();
    exp_wdata_q.delete();
    foreach (model_rf[r]) begin
      model_rf[r] = '0;
    end
    for (int step = 0; step < MAX_STEPS && !done; step++) begin
      w   = model_mem[pc[WORD_ADDR_HI:WORD_ADDR_LO]];
      rd  = w[RD_HI:RD_LO];
      a   = model_rf[w[RS1_HI:RS1_LO]];
      b   = model_rf[w[RS2_HI:RS2_LO]];
      // 13-bit immediate, sign extended by 19
      imm = {{19{w[IMM_HI]}}, w[IMM_HI:IMM_LO]};
      ea  = a + imm;
      case (opcode_e'(w[OPC_HI:OPC_LO]))
        OP_ADD:  write_back(pc, rd, a + b);
        OP_ADDI: write_back(pc, rd, a + imm);
        OP_LW:   write_back(pc, rd, model_mem[ea[WORD_ADDR_HI:WORD_ADDR_LO]]);
        OP_SW: begin
          model_mem[ea[WORD_ADDR_HI:WORD_ADDR_LO]] = b;
          add_expect(pc, 1'b0, '0, '0);
        end
        OP_BNE:  add_expect(pc, 1'b0, '0, '0);
        OP_HALT: begin
          add_expect(pc, 1'b0, '0, '0);
          done = 1'b1;
        end
        default: begin
          $display("reference model hit an unknown opcode at pc %h", pc);
          errors++;
          done = 1'b1;
        end
      endcase
      // taken branch jumps by imm words
      if (opcode_e'(w[OPC_HI:OPC_LO]) == OP_BNE && a != b) begin
        pc = pc + (imm << 2);
      end else begin
        pc = pc + 32'd4;
      end
    end
    if (!done) begin
      $display("reference model ran %0d steps without reaching HALT", MAX_STEPS);
      errors++;
    end
  endtask

  // ----------------------------------------
  // run one loaded program
  // ----------------------------------------

  task automatic run_program();
    int   cycles;
    logic dropped;
    model_run();
    exp_commits += exp_pc_q.size();
    drive_slot();
    run = 1'b1;
    foreach (exp_pc_q[i]) begin
      trace_checker_inst.check_trace(exp_pc_q[i], exp_wen_q[i], exp_waddr_q[i],
                                     exp_wdata_q[i]);
    end
    cycles = 0;
    @(negedge clk);
    while (halted !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (halted !== 1'b1) begin
      $display("core never raised halted after the HALT commit");
      errors++;
    end
    // halted must hold, extra commits show up in the count
    dropped = 1'b0;
    repeat (HALT_WINDOW) begin
      @(negedge clk);
      dropped = dropped | (halted !== 1'b1);
    end
    if (dropped) begin
      $display("halted fell again while the core should stay stopped");
      errors++;
    end
    drive_slot();
    if (trace_checker_inst.commits != exp_commits) begin
      $display("FAIL trace_val count: expected %h, got %h", exp_commits,
               trace_checker_inst.commits);
      errors++;
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------

  task automatic test_apb_rw();
    for (int i = 0; i < 8; i++) begin
      poke_word(200 + 5 * i, rand_bits(32));
      // second write must win
      poke_word(200 + 5 * i, rand_bits(32));
    end
    for (int i = 0; i < 8; i++) begin
      check_word(200 + 5 * i);
    end
  endtask

  task automatic test_alu_r0();
    start_program();
    emit(assemble(OP_ADDI, 1, 0, 0, 5));
    emit(assemble(OP_ADDI, 2, 0, 0, -3));
    emit(assemble(OP_ADD, 3, 1, 2, 0));
    // write to r0 is dropped
    emit(assemble(OP_ADDI, 0, 1, 0, 7));
    emit(assemble(OP_ADD, 4, 0, 1, 0));
    emit(assemble(OP_ADDI, 5, 3, 0, 100));
    emit(assemble(OP_ADD, 6, 5, 5, 0));
    emit(assemble(OP_HALT, 0, 0, 0, 0));
    run_program();
  endtask

  task automatic test_load_store();
    start_program();
    poke_word(DATA_BASE, rand_bits(32));
    poke_word(DATA_BASE + 1, rand_bits(32));
    emit(assemble(OP_ADDI, 1, 0, 0, DATA_BASE * 4));
    emit(assemble(OP_LW, 2, 1, 0, 0));
    emit(assemble(OP_LW, 3, 1, 0, 4));
    emit(assemble(OP_ADD, 4, 2, 3, 0));
    emit(assemble(OP_SW, 0, 1, 4, 8));
    emit(assemble(OP_LW, 5, 1, 0, 8));
    emit(assemble(OP_ADDI, 6, 5, 0, 1));
    emit(assemble(OP_SW, 0, 1, 6, 12));
    // load into r0 reports no write
    emit(assemble(OP_LW, 0, 1, 0, 0));
    emit(assemble(OP_HALT, 0, 0, 0, 0));
    run_program();
    for (int i = 0; i < 4; i++) begin
      check_word(DATA_BASE + i);
    end
  endtask

  task automatic test_branch_loop();
    start_program();
    emit(assemble(OP_ADDI, 1, 0, 0, 5));
    emit(assemble(OP_ADDI, 2, 0, 0, 0));
    // loop body at word 2
    emit(assemble(OP_ADDI, 2, 2, 0, 3));
    emit(assemble(OP_ADDI, 1, 1, 0, -1));
    emit(assemble(OP_BNE, 0, 1, 0, -2));
    // forward skip over word 6
    emit(assemble(OP_BNE, 0, 2, 0, 2));
    emit(assemble(OP_ADDI, 4, 0, 0, 1));
    emit(assemble(OP_ADDI, 5, 2, 0, 0));
    emit(assemble(OP_HALT, 0, 0, 0, 0));
    run_program();
  endtask

  task automatic test_halt_holds();
    start_program();
    emit(assemble(OP_ADDI, 1, 0, 0, 11));
    emit(assemble(OP_HALT, 0, 0, 0, 0));
    // past the halt, never committed
    emit(assemble(OP_ADDI, 1, 0, 0, 22));
    emit(assemble(OP_ADDI, 2, 0, 0, 33));
    run_program();
  endtask

  task automatic test_random_alu();
    opcode_e op;
    int      rd;
    int      rs1;
    int      rs2;
    int      imm;
    start_program();
    // seed r1..r7 so nothing reads an unwritten register
    for (int r = 1; r < 8; r++) begin
      imm = rand_bits(13);
      emit(assemble(OP_ADDI, r, 0, 0, imm));
    end
    for (int i = 0; i < 24; i++) begin
      op  = rand_bits(1) ? OP_ADDI : OP_ADD;
      rd  = rand_bits(3);
      rs1 = rand_bits(3);
      rs2 = rand_bits(3);
      imm = rand_bits(13);
      emit(assemble(op, rd, rs1, rs2, imm));
    end
    emit(assemble(OP_HALT, 0, 0, 0, 0));
    run_program();
  endtask

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    run         = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    errors      = 0;
    exp_commits = 0;
    prog_len    = 0;
    lfsr        = 16'd40;
    restart_core();
    test_apb_rw();
    test_alu_r0();
    test_load_store();
    test_branch_loop();
    test_halt_holds();
    test_random_alu();
    $display("errors: testbench %0d, trace checker %0d", errors, trace_checker_inst.errors);
    if (errors == 0 && trace_checker_inst.errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog, sized from tests times program length
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/inst_trace_checker.sv
// commit trace checker: waits for each committed instruction and compares it with expected values
`timescale 1ns/1ns
`default_nettype none

module inst_trace_checker (
  input  logic               clk,
  input  logic               trace_val,
  input  core_pkg::addr_t    trace_pc,
  input  logic               trace_wen,
  input  core_pkg::reg_idx_t trace_waddr,
  input  core_pkg::word_t    trace_wdata
);
  import core_pkg::*;

  // cycles to wait for one commit
  localparam int COMMIT_TIMEOUT = 200;

  int errors  = 0;
  // all trace pulses seen, expected or not
  int commits = 0;

  // trace changes on posedge, so negedge sees it settled
  always @(negedge clk) begin
    if (trace_val === 1'b1) begin
      commits <= commits + 1;
    end
  end

  // ----------------------------------------
  // one expected commit
  // ----------------------------------------

  task automatic check_trace(input addr_t exp_pc, input logic exp_wen,
                             input reg_idx_t exp_waddr, input word_t exp_wdata);
    int cycles;
    cycles = 0;
    // always step past the previous pulse first
    @(negedge clk);
    while (trace_val !== 1'b1 && cycles < COMMIT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (trace_val !== 1'b1) begin
      $display("no commit seen for pc %h within %0d cycles", exp_pc, COMMIT_TIMEOUT);
      errors++;
    end else begin
      if (trace_pc !== exp_pc) begin
        $display("FAIL trace_pc: expected %h, got %h", exp_pc, trace_pc);
        errors++;
      end
      if (trace_wen !== exp_wen) begin
        $display("FAIL trace_wen at pc %h: expected %h, got %h", exp_pc, exp_wen, trace_wen);
        errors++;
      end
      // register and data only mean something on a write
      if (exp_wen && trace_waddr !== exp_waddr) begin
        $display("FAIL trace_waddr at pc %h: expected %h, got %h",
                 exp_pc, exp_waddr, trace_waddr);
        errors++;
      end
      if (exp_wen && trace_wdata !== exp_wdata) begin
        $display("FAIL trace_wdata at pc %h: expected %h, got %h",
                 exp_pc, exp_wdata, trace_wdata);
        errors++;
      end
    end
  endtask

endmodule

`default_nettype wire

//--- src/tiny_core_top.sv
// tiny core top: fetch, execute, APB port and memory arbiter with the commit trace
`timescale 1ns/1ns
`default_nettype none

module tiny_core_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                run,
  // apb
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  core_pkg::addr_t     paddr,
  input  core_pkg::word_t     pwdata,
  output core_pkg::word_t     prdata,
  output logic                pready,
  // commit trace
  output logic                trace_val,
  output core_pkg::addr_t     trace_pc,
  output logic                trace_wen,
  output core_pkg::reg_idx_t  trace_waddr,
  output core_pkg::word_t     trace_wdata,
  output logic                halted
);
  import core_pkg::*;
  import mem_pkg::*;

  // fetch to execute
  logic      inst_valid;
  logic      inst_ready;
  word_t     inst;
  addr_t     inst_pc;
  logic      redirect;
  addr_t     redirect_pc;

  // ----------------------------------------
  // memory requesters
  // ----------------------------------------

  logic      lsu_req;
  logic      lsu_we;
  logic      lsu_gnt;
  mem_addr_t lsu_addr;
  word_t     lsu_wdata;
  word_t     lsu_rdata;
  logic      fetch_req;
  logic      fetch_gnt;
  mem_addr_t fetch_addr;
  word_t     fetch_rdata;
  logic      apb_req;
  logic      apb_we;
  logic      apb_gnt;
  mem_addr_t apb_addr;
  word_t     apb_wdata;
  word_t     apb_rdata;

  fetch_unit fetch_unit_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .run         (run),
    .halted      (halted),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .inst_pc     (inst_pc),
    .inst_ready  (inst_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mem_req     (fetch_req),
    .mem_addr    (fetch_addr),
    .mem_gnt     (fetch_gnt),
    .mem_rdata   (fetch_rdata)
  );

  exec_unit exec_unit_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .inst_pc     (inst_pc),
    .inst_ready  (inst_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mem_req     (lsu_req),
    .mem_we      (lsu_we),
    .mem_addr    (lsu_addr),
    .mem_wdata   (lsu_wdata),
    .mem_gnt     (lsu_gnt),
    .mem_rdata   (lsu_rdata),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_wen   (trace_wen),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .halted      (halted)
  );

  apb_mem_port apb_mem_port_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .mem_req   (apb_req),
    .mem_we    (apb_we),
    .mem_addr  (apb_addr),
    .mem_wdata (apb_wdata),
    .mem_gnt   (apb_gnt),
    .mem_rdata (apb_rdata)
  );

  // fetch only reads
  mem_arbiter mem_arbiter_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .lsu_req     (lsu_req),
    .lsu_we      (lsu_we),
    .lsu_addr    (lsu_addr),
    .lsu_wdata   (lsu_wdata),
    .lsu_gnt     (lsu_gnt),
    .lsu_rdata   (lsu_rdata),
    .fetch_req   (fetch_req),
    .fetch_we    (1'b0),
    .fetch_addr  (fetch_addr),
    .fetch_wdata ('0),
    .fetch_gnt   (fetch_gnt),
    .fetch_rdata (fetch_rdata),
    .apb_req     (apb_req),
    .apb_we      (apb_we),
    .apb_addr    (apb_addr),
    .apb_wdata   (apb_wdata),
    .apb_gnt     (apb_gnt),
    .apb_rdata   (apb_rdata)
  );

endmodule

`default_nettype wire

//--- src/apb_mem_port.sv
// APB slave port: turns bus transfers into shared memory requests
`timescale 1ns/1ns
`default_nettype none

module apb_mem_port (
  input  logic               clk,
  input  logic               arst_n,
  // apb
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  core_pkg::addr_t    paddr,
  input  core_pkg::word_t    pwdata,
  output core_pkg::word_t    prdata,
  output logic               pready,
  // memory request port
  output logic               mem_req,
  output logic               mem_we,
  output mem_pkg::mem_addr_t mem_addr,
  output core_pkg::word_t    mem_wdata,
  input  logic               mem_gnt,
  input  core_pkg::word_t    mem_rdata
);
  import mem_pkg::*;

  // read granted, data arrives this cycle
  logic rd_wait;

  // fields stay stable through the access phase
  assign mem_we    = pwrite;
  assign mem_addr  = paddr[WORD_ADDR_HI:WORD_ADDR_LO];
  assign mem_wdata = pwdata;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_req <= 1'b0;
      rd_wait <= 1'b0;
      pready  <= 1'b0;
    end else begin
      pready <= 1'b0;
      if (mem_req) begin
        if (mem_gnt) begin
          mem_req <= 1'b0;
          pready  <= pwrite;
          rd_wait <= !pwrite;
        end
      end else if (rd_wait) begin
        rd_wait <= 1'b0;
        pready  <= 1'b1;
      end else if (psel && penable && !pready) begin
        // access phase, not yet served
        mem_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_wait) begin
      prdata <= mem_rdata;
    end
  end

  a_penable_psel : assert property (
    @(posedge clk) disable iff (!arst_n) penable |-> psel);

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
// memory arbiter: fixed-priority grant among load/store, fetch and APB, plus the memory array
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  logic               clk,
  input  logic               arst_n,
  // load/store, highest priority
  input  logic               lsu_req,
  input  logic               lsu_we,
  input  mem_pkg::mem_addr_t lsu_addr,
  input  core_pkg::word_t    lsu_wdata,
  output logic               lsu_gnt,
  output core_pkg::word_t    lsu_rdata,
  // fetch
  input  logic               fetch_req,
  input  logic               fetch_we,
  input  mem_pkg::mem_addr_t fetch_addr,
  input  core_pkg::word_t    fetch_wdata,
  output logic               fetch_gnt,
  output core_pkg::word_t    fetch_rdata,
  // apb, lowest priority
  input  logic               apb_req,
  input  logic               apb_we,
  input  mem_pkg::mem_addr_t apb_addr,
  input  core_pkg::word_t    apb_wdata,
  output logic               apb_gnt,
  output core_pkg::word_t    apb_rdata
);
  import core_pkg::*;
  import mem_pkg::*;

  logic [NUM_REQ-1:0] req_vec;
  logic [NUM_REQ-1:0] we_vec;
  logic [NUM_REQ-1:0] gnt_vec;
  // read granted last cycle, per requester
  logic [NUM_REQ-1:0] rd_gnt_q;
  mem_addr_t          addr_vec [NUM_REQ];
  word_t              wdata_vec [NUM_REQ];
  mem_addr_t          sel_addr;
  word_t              sel_wdata;
  logic               sel_we;
  word_t              mem [MEM_WORDS];
  word_t              rd_q;

  assign req_vec = {apb_req, fetch_req, lsu_req};
  assign we_vec  = {apb_we, fetch_we, lsu_we};

  assign addr_vec[REQ_LSU]    = lsu_addr;
  assign addr_vec[REQ_FETCH]  = fetch_addr;
  assign addr_vec[REQ_APB]    = apb_addr;
  assign wdata_vec[REQ_LSU]   = lsu_wdata;
  assign wdata_vec[REQ_FETCH] = fetch_wdata;
  assign wdata_vec[REQ_APB]   = apb_wdata;

  // ----------------------------------------
  // grant, lowest index first
  // ----------------------------------------

  always_comb begin
    gnt_vec   = '0;
    sel_we    = 1'b0;
    sel_addr  = addr_vec[REQ_LSU];
    sel_wdata = wdata_vec[REQ_LSU];
    for (int i = NUM_REQ - 1; i >= 0; i--) begin
      if (req_vec[i]) begin
        gnt_vec   = '0;
        gnt_vec[i] = 1'b1;
        sel_we    = we_vec[i];
        sel_addr  = addr_vec[i];
        sel_wdata = wdata_vec[i];
      end
    end
  end

  assign lsu_gnt   = gnt_vec[REQ_LSU];
  assign fetch_gnt = gnt_vec[REQ_FETCH];
  assign apb_gnt   = gnt_vec[REQ_APB];

  // single port array, write at the grant edge
  always_ff @(posedge clk) begin
    if (|gnt_vec) begin
      if (sel_we) begin
        mem[sel_addr] <= sel_wdata;
      end else begin
        rd_q <= mem[sel_addr];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_gnt_q <= '0;
    end else begin
      rd_gnt_q <= gnt_vec & ~we_vec;
    end
  end

  // read data only to its owner
  assign lsu_rdata   = rd_gnt_q[REQ_LSU] ? rd_q : '0;
  assign fetch_rdata = rd_gnt_q[REQ_FETCH] ? rd_q : '0;
  assign apb_rdata   = rd_gnt_q[REQ_APB] ? rd_q : '0;

  a_onehot_gnt : assert property (
    @(posedge clk) disable iff (!arst_n) $onehot0({apb_gnt, fetch_gnt, lsu_gnt}));

endmodule

`default_nettype wire

//--- src/exec_unit.sv
// execute unit: decode, register file, ALU, branches, load/store and the commit trace
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
  input  logic                clk,
  input  logic                arst_n,
  // from fetch
  input  logic                inst_valid,
  input  core_pkg::word_t     inst,
  input  core_pkg::addr_t     inst_pc,
  output logic                inst_ready,
  output logic                redirect,
  output core_pkg::addr_t     redirect_pc,
  // load/store port
  output logic                mem_req,
  output logic                mem_we,
  output mem_pkg::mem_addr_t  mem_addr,
  output core_pkg::word_t     mem_wdata,
  input  logic                mem_gnt,
  input  core_pkg::word_t     mem_rdata,
  // commit trace
  output logic                trace_val,
  output core_pkg::addr_t     trace_pc,
  output logic                trace_wen,
  output core_pkg::reg_idx_t  trace_waddr,
  output core_pkg::word_t     trace_wdata,
  output logic                halted
);
  import core_pkg::*;
  import mem_pkg::*;

  exec_state_e state;
  exec_state_e state_nxt;
  word_t       rf [2**$bits(reg_idx_t)];

  // decode
  opcode_e  op;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  imm_t     imm;
  word_t    imm_ext;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    sum;
  logic     fire;

  // held load/store
  logic      ls_we;
  mem_addr_t ls_addr;
  word_t     ls_wdata;
  reg_idx_t  ls_rd;
  addr_t     ls_pc;

  // commit this cycle
  logic     commit;
  logic     c_wen;
  reg_idx_t c_waddr;
  word_t    c_wdata;
  addr_t    c_pc;

  assign op      = opcode_e'(inst[OPC_HI:OPC_LO]);
  assign rd      = inst[RD_HI:RD_LO];
  assign rs1     = inst[RS1_HI:RS1_LO];
  assign rs2     = inst[RS2_HI:RS2_LO];
  assign imm     = inst[IMM_HI:IMM_LO];
  assign imm_ext = {{($bits(word_t) - $bits(imm_t)){imm[IMM_HI]}}, imm};

  // r0 reads zero
  assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];
  // add result and load/store byte address
  assign sum     = rs1_val + ((op == OP_ADD) ? rs2_val : imm_ext);

  // hold off for one cycle while fetch turns around
  assign inst_ready = (state == EX_IDLE) && !redirect;
  assign fire       = inst_valid && inst_ready;

  assign mem_req   = (state == EX_MEM_WAIT);
  assign mem_we    = ls_we;
  assign mem_addr  = ls_addr;
  assign mem_wdata = ls_wdata;

  // ----------------------------------------
  // next state and commit
  // ----------------------------------------

  always_comb begin
    state_nxt = state;
    commit    = 1'b0;
    c_wen     = 1'b0;
    c_waddr   = rd;
    c_wdata   = sum;
    c_pc      = inst_pc;
    case (state)
      EX_IDLE: begin
        if (fire) begin
          case (op)
            OP_LW, OP_SW: state_nxt = EX_MEM_WAIT;
            OP_ADD, OP_ADDI: begin
              commit = 1'b1;
              c_wen  = (rd != '0);
            end
            OP_HALT: begin
              commit    = 1'b1;
              state_nxt = EX_HALTED;
            end
            // bne and unknown opcodes retire without a write
            default: commit = 1'b1;
          endcase
        end
      end
      EX_MEM_WAIT: begin
        if (mem_gnt) begin
          // store retires the cycle after its grant
          commit    = ls_we;
          c_pc      = ls_pc;
          state_nxt = ls_we ? EX_IDLE : EX_MEM_DATA;
        end
      end
      EX_MEM_DATA: begin
        commit    = 1'b1;
        c_pc      = ls_pc;
        c_waddr   = ls_rd;
        c_wdata   = mem_rdata;
        c_wen     = (ls_rd != '0);
        state_nxt = EX_IDLE;
      end
      default: state_nxt = EX_HALTED;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= EX_IDLE;
      trace_val <= 1'b0;
      redirect  <= 1'b0;
      halted    <= 1'b0;
    end else begin
      state     <= state_nxt;
      trace_val <= commit;
      redirect  <= fire && (op == OP_BNE) && (rs1_val != rs2_val);
      // rises the cycle after the halt commit
      halted    <= (state == EX_HALTED);
    end
  end

  always_ff @(posedge clk) begin
    trace_pc    <= c_pc;
    trace_wen   <= c_wen;
    trace_waddr <= c_waddr;
    trace_wdata <= c_wdata;
    // target is pc plus imm words
    redirect_pc <= inst_pc + {imm_ext[29:0], 2'b00};
    if (commit && c_wen) begin
      rf[c_waddr] <= c_wdata;
    end
    if (fire) begin
      ls_we    <= (op == OP_SW);
      ls_addr  <= sum[WORD_ADDR_HI:WORD_ADDR_LO];
      ls_wdata <= rs2_val;
      ls_rd    <= rd;
      ls_pc    <= inst_pc;
    end
  end

  a_no_trace_after_halt : assert property (
    @(posedge clk) disable iff (!arst_n) halted |-> !trace_val);

  // one grant per access, then idle or data wait with no request
  a_req_drops_after_gnt : assert property (
    @(posedge clk) disable iff (!arst_n) (mem_req && mem_gnt) |=> !mem_req);

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
// fetch unit: reads instructions from shared memory into a one-entry buffer for execute
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               run,
  input  logic               halted,
  // execute side
  output logic               inst_valid,
  output core_pkg::word_t    inst,
  output core_pkg::addr_t    inst_pc,
  input  logic               inst_ready,
  input  logic               redirect,
  input  core_pkg::addr_t    redirect_pc,
  // memory request port
  output logic               mem_req,
  output mem_pkg::mem_addr_t mem_addr,
  input  logic               mem_gnt,
  input  core_pkg::word_t    mem_rdata
);
  import core_pkg::*;
  import mem_pkg::*;

  addr_t fetch_pc;
  addr_t pend_pc;
  // read data returns this cycle
  logic  pend;
  // returning read belongs to the old path
  logic  stale;
  // request seen but not yet granted
  logic  req_hold;
  logic  want;

  // one read at a time and only into a free or draining buffer
  assign want     = run && !halted && !pend && (!inst_valid || inst_ready);
  assign mem_req  = want || req_hold;
  assign mem_addr = fetch_pc[WORD_ADDR_HI:WORD_ADDR_LO];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_pc   <= RESET_PC;
      inst_valid <= 1'b0;
      pend       <= 1'b0;
      stale      <= 1'b0;
      req_hold   <= 1'b0;
    end else begin
      pend     <= mem_req && mem_gnt;
      stale    <= mem_req && mem_gnt && redirect;
      req_hold <= mem_req && !mem_gnt;
      if (redirect) begin
        // restart on the new path and drop the buffer
        fetch_pc   <= redirect_pc;
        inst_valid <= 1'b0;
      end else begin
        if (mem_req && mem_gnt) begin
          fetch_pc <= fetch_pc + 32'd4;
        end
        if (pend && !stale) begin
          inst_valid <= 1'b1;
        end else if (inst_valid && inst_ready) begin
          inst_valid <= 1'b0;
        end
      end
    end
  end

  // buffer payload
  always_ff @(posedge clk) begin
    if (mem_req && mem_gnt) begin
      pend_pc <= fetch_pc;
    end
    if (pend) begin
      inst    <= mem_rdata;
      inst_pc <= pend_pc;
    end
  end

  // wrong-path data never reaches execute
  a_no_valid_on_stale : assert property (
    @(posedge clk) disable iff (!arst_n) stale |=> !inst_valid);

endmodule

`default_nettype wire

//--- src/mem_pkg.sv
// memory package: shared memory size, word index and arbiter requester numbering
`default_nettype none

package mem_pkg;

  // 256 words of 32 bits
  localparam int MEM_WORDS = 256;

  // word index into the array
  typedef logic [7:0] mem_addr_t;

  // word index sits in byte address bits 9..2
  localparam int WORD_ADDR_HI = 9;
  localparam int WORD_ADDR_LO = 2;

  // ----------------------------------------
  // requesters, lower index wins
  // ----------------------------------------

  localparam int NUM_REQ = 3;

  localparam int REQ_LSU   = 0;
  localparam int REQ_FETCH = 1;
  localparam int REQ_APB   = 2;

endpackage

`default_nettype wire

//--- src/core_pkg.sv
// core package: instruction-set word types, field positions, opcodes and execute states
`default_nettype none

package core_pkg;

  // ----------------------------------------
  // data widths
  // ----------------------------------------

  // data and instruction word
  typedef logic [31:0] word_t;
  // byte address, also the pc
  typedef logic [31:0] addr_t;
  // one of 32 registers
  typedef logic [4:0] reg_idx_t;
  // signed branch and memory offset
  typedef logic signed [12:0] imm_t;

  // ----------------------------------------
  // instruction fields
  // ----------------------------------------

  localparam int OPC_HI = 31;
  localparam int OPC_LO = 28;
  localparam int RD_HI  = 27;
  localparam int RD_LO  = 23;
  localparam int RS1_HI = 22;
  localparam int RS1_LO = 18;
  localparam int RS2_HI = 17;
  localparam int RS2_LO = 13;
  localparam int IMM_HI = 12;
  localparam int IMM_LO = 0;

  // first fetch address after reset
  localparam addr_t RESET_PC = '0;

  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_ADDI = 4'h1,
    OP_LW   = 4'h2,
    OP_SW   = 4'h3,
    OP_BNE  = 4'h4,
    OP_HALT = 4'h5
  } opcode_e;

  // execute FSM
  typedef enum logic [1:0] {
    EX_IDLE,
    EX_MEM_WAIT,
    EX_MEM_DATA,
    EX_HALTED
  } exec_state_e;

endpackage

`default_nettype wire
